//--- verilog/ipic_pkg.sv
// Interrupt controller shared definitions
`default_nettype none

package ipic_pkg;

    //----------------------------------------
    // CSR word
    //----------------------------------------
    localparam int IPIC_XLEN = 32;                  // CSR data width

    typedef logic [IPIC_XLEN-1:0] ipic_word_t;

    //----------------------------------------
    // Register map
    //----------------------------------------
    typedef enum logic [2:0] {
        CISV  = 3'd0,   // Current vector in service
        CICSR = 3'd1,   // Reserved, reads zero
        IPR   = 3'd2,   // Pending
        ISVR  = 3'd3,   // In service
        EOI   = 3'd4,   // End of interrupt
        SOI   = 3'd5,   // Start of interrupt
        IDX   = 3'd6,   // Line index for ICSR
        ICSR  = 3'd7    // Per-line control window
    } ipic_addr_e;

    //----------------------------------------
    // ICSR fields
    //----------------------------------------
    localparam int ICSR_IP  = 0;                    // Pending
    localparam int ICSR_IE  = 1;                    // Enable
    localparam int ICSR_IM  = 2;                    // Mode, 1 is edge
    localparam int ICSR_INV = 3;                    // Line inversion
    localparam int ICSR_IS  = 4;                    // In service

    localparam int ICSR_PRV_LSB = 8;                // Privilege field
    localparam int ICSR_PRV_MSB = 9;

    // Only machine mode handled here
    localparam logic [1:0] IPIC_PRV_M = 2'd3;

    localparam int ICSR_LN_LSB = 16;                // Line number field start

endpackage : ipic_pkg

`default_nettype wire

//--- verilog/ipic_reg_if.sv
// Register access bundle
`timescale 1ns/1ns
`default_nettype none

interface ipic_reg_if #(
    parameter int N_LINES = 16
) ();
    import ipic_pkg::*;

    localparam int IDX_W = $clog2(N_LINES);
    localparam int VEC_W = IDX_W + 1;

    // Write side, one strobe per access
    logic               wr_ipr;
    logic               wr_eoi;
    logic               wr_soi;
    logic               wr_idx;
    logic               wr_icsr;
    ipic_word_t         wdata;

    // Register values for read back
    logic [N_LINES-1:0] ipr;
    logic [N_LINES-1:0] ier;
    logic [N_LINES-1:0] imr;
    logic [N_LINES-1:0] iinvr;
    logic [N_LINES-1:0] isvr;
    logic [IDX_W-1:0]   idx;
    logic [VEC_W-1:0]   cisv;
    logic               serv_vd;        // Some line in service

    modport csr (
        output wr_ipr, wr_eoi, wr_soi, wr_idx, wr_icsr, wdata,
        input  ipr, ier, imr, iinvr, isvr, idx, cisv, serv_vd
    );

    modport line (
        input  wr_ipr, wr_idx, wr_icsr, wdata,
        output ipr, ier, imr, iinvr, idx
    );

    modport service (
        input  wr_eoi, wr_soi,
        output isvr, cisv, serv_vd
    );

endinterface : ipic_reg_if

`default_nettype wire

//--- verilog/ipic_line_cond.sv
// IRQ line synchronizer and change detect
`timescale 1ns/1ns
`default_nettype none

module ipic_line_cond #(
    parameter int N_LINES = 16,
    parameter bit SYNC_EN = 1'b1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [N_LINES-1:0] irq_lines_i,    // Raw external lines
    output logic [N_LINES-1:0] lines_o,        // Lines in clk domain
    output logic [N_LINES-1:0] changed_o       // Differs from last sample
);

    logic [N_LINES-1:0] lines;
    logic [N_LINES-1:0] lines_dly_q;           // Previous sample

    //----------------------------------------
    // Optional two-flop synchronizer
    //----------------------------------------
    if (SYNC_EN) begin : g_sync
        logic [N_LINES-1:0] meta_q;            // First stage, may go metastable
        logic [N_LINES-1:0] sync_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                meta_q <= '0;
                sync_q <= '0;
            end else begin
                meta_q <= irq_lines_i;
                sync_q <= meta_q;
            end
        end

        assign lines = sync_q;
    end else begin : g_nosync
        assign lines = irq_lines_i;            // Lines already synchronous
    end

    //----------------------------------------
    // Change detect
    //----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_dly_q <= '0;
        end else begin
            lines_dly_q <= lines;
        end
    end

    assign lines_o   = lines;
    assign changed_o = lines ^ lines_dly_q;    // Any toggle, either direction

endmodule : ipic_line_cond

`default_nettype wire

//--- verilog/ipic_csr_port.sv
// CSR access decode and read mux
`timescale 1ns/1ns
`default_nettype none

module ipic_csr_port #(
    parameter int N_LINES = 16
) (
    input  logic                   r_req_i,    // Single-cycle read
    input  logic                   w_req_i,    // Single-cycle write
    input  ipic_pkg::ipic_addr_e   addr_i,
    input  ipic_pkg::ipic_word_t   wdata_i,
    output ipic_pkg::ipic_word_t   rdata_o,
    ipic_reg_if.csr                regs
);
    import ipic_pkg::*;

    localparam int                 IDX_W    = $clog2(N_LINES);
    localparam int                 VEC_W    = IDX_W + 1;
    localparam logic [VEC_W-1:0]   VOID_VEC = VEC_W'(N_LINES);

    //----------------------------------------
    // Write strobes
    //----------------------------------------
    always_comb begin
        regs.wr_ipr  = 1'b0;
        regs.wr_eoi  = 1'b0;
        regs.wr_soi  = 1'b0;
        regs.wr_idx  = 1'b0;
        regs.wr_icsr = 1'b0;
        if (w_req_i) begin
            case (addr_i)
                IPR:     regs.wr_ipr  = 1'b1;  // Write 1 to clear
                EOI:     regs.wr_eoi  = 1'b1;  // Data ignored
                SOI:     regs.wr_soi  = 1'b1;  // Data ignored
                IDX:     regs.wr_idx  = 1'b1;
                ICSR:    regs.wr_icsr = 1'b1;
                default: ;                     // CISV, CICSR, ISVR read only
            endcase
        end
    end

    assign regs.wdata = wdata_i;

    //----------------------------------------
    // Read mux, zero when idle
    //----------------------------------------
    always_comb begin
        rdata_o = '0;
        if (r_req_i) begin
            case (addr_i)
                CISV: begin
                    // Void vector when nothing in service
                    rdata_o = regs.serv_vd ? ipic_word_t'(regs.cisv)
                                           : ipic_word_t'(VOID_VEC);
                end
                IPR:  rdata_o = ipic_word_t'(regs.ipr);
                ISVR: rdata_o = ipic_word_t'(regs.isvr);
                IDX:  rdata_o = ipic_word_t'(regs.idx);
                ICSR: begin
                    rdata_o[ICSR_IP]  = regs.ipr[regs.idx];
                    rdata_o[ICSR_IE]  = regs.ier[regs.idx];
                    rdata_o[ICSR_IM]  = regs.imr[regs.idx];
                    rdata_o[ICSR_INV] = regs.iinvr[regs.idx];
                    rdata_o[ICSR_IS]  = regs.isvr[regs.idx];
                    rdata_o[ICSR_PRV_MSB:ICSR_PRV_LSB] = IPIC_PRV_M;
                    rdata_o[ICSR_LN_LSB +: IDX_W]      = regs.idx;   // Echo of index
                end
                default: rdata_o = '0;         // EOI, SOI, CICSR
            endcase
        end
    end

endmodule : ipic_csr_port

`default_nettype wire

//--- verilog/ipic_line_regs.sv
// Per-line pending, enable, mode and inversion registers
`timescale 1ns/1ns
`default_nettype none

module ipic_line_regs #(
    parameter int N_LINES = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [N_LINES-1:0]         lines_i,        // Conditioned lines
    input  logic [N_LINES-1:0]         changed_i,      // Toggled this cycle
    input  logic                       start_i,        // SOI accepted
    input  logic [$clog2(N_LINES)-1:0] start_idx_i,    // Line being started
    output logic [N_LINES-1:0]         req_vec_o,      // Pending and enabled
    ipic_reg_if.line                   regs
);
    import ipic_pkg::*;

    localparam int IDX_W = $clog2(N_LINES);

    logic [IDX_W-1:0]   idx_q;
    logic [N_LINES-1:0] ipr_q,   ipr_next;
    logic [N_LINES-1:0] ier_q,   ier_next;
    logic [N_LINES-1:0] imr_q,   imr_next;
    logic [N_LINES-1:0] iinvr_q, iinvr_next;
    logic [N_LINES-1:0] lvl;                   // Active level after inversion
    logic [N_LINES-1:0] clr_req;               // Pending clear requests
    logic [N_LINES-1:0] clr;                   // Requests that are allowed

    //----------------------------------------
    // ICSR window write
    //----------------------------------------
    always_comb begin
        ier_next   = ier_q;
        imr_next   = imr_q;
        iinvr_next = iinvr_q;
        if (regs.wr_icsr) begin
            ier_next[idx_q]   = regs.wdata[ICSR_IE];
            imr_next[idx_q]   = regs.wdata[ICSR_IM];
            iinvr_next[idx_q] = regs.wdata[ICSR_INV];
        end
    end

    // New inversion takes effect in the same cycle
    assign lvl = lines_i ^ iinvr_next;

    //----------------------------------------
    // Pending update
    //----------------------------------------
    always_comb begin
        clr_req = '0;
        if (regs.wr_ipr) begin
            clr_req = regs.wdata[N_LINES-1:0];     // One clear bit per line
        end
        if (regs.wr_icsr) begin
            clr_req[idx_q] = clr_req[idx_q] | regs.wdata[ICSR_IP];
        end
        if (start_i) begin
            clr_req[start_idx_i] = 1'b1;           // Serviced line drops pending
        end
    end

    // An active level re-asserts pending in level mode, so no clear there
    assign clr = clr_req & (~lvl | imr_next);

    // Level mode follows lvl, edge mode sets on active toggle and holds
    assign ipr_next = ~clr & ((~imr_q & lvl) | (imr_q & (ipr_q | (changed_i & lvl))));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q   <= '0;
            ipr_q   <= '0;
            ier_q   <= '0;
            imr_q   <= '0;
            iinvr_q <= '0;
        end else begin
            if (regs.wr_idx) begin
                idx_q <= regs.wdata[IDX_W-1:0];
            end
            ipr_q   <= ipr_next;
            ier_q   <= ier_next;
            imr_q   <= imr_next;
            iinvr_q <= iinvr_next;
        end
    end

    assign regs.idx   = idx_q;
    assign regs.ipr   = ipr_q;
    assign regs.ier   = ier_q;
    assign regs.imr   = imr_q;
    assign regs.iinvr = iinvr_q;
    assign req_vec_o  = ipr_q & ier_q;

endmodule : ipic_line_regs

`default_nettype wire

//--- verilog/ipic_prio_search.sv
// Lowest set bit search tree
`timescale 1ns/1ns
`default_nettype none

module ipic_prio_search #(
    parameter int N_LINES = 16                 // Power of two
) (
    input  logic [N_LINES-1:0]         vec_i,
    output logic                       vd_o,   // Any bit set
    output logic [$clog2(N_LINES)-1:0] idx_o   // Lowest set position
);

    localparam int IDX_W = $clog2(N_LINES);

    logic             node_vd  [N_LINES];
    logic [IDX_W-1:0] node_idx [N_LINES];

    // Each stage pairs nodes 2n and 2n+1 into node n, halving the count
    always_comb begin
        for (int n = 0; n < N_LINES; n++) begin
            node_vd[n]  = vec_i[n];
            node_idx[n] = '0;
        end
        for (int l = 0; l < IDX_W; l++) begin
            for (int n = 0; n < (N_LINES >> (l + 1)); n++) begin
                if (node_vd[2*n]) begin            // Left child wins ties
                    node_vd[n]  = 1'b1;
                    node_idx[n] = node_idx[2*n];
                end else begin
                    node_vd[n]  = node_vd[2*n+1];
                    node_idx[n] = node_idx[2*n+1] | IDX_W'(1 << l);
                end
            end
        end
    end

    assign vd_o  = node_vd[0];
    assign idx_o = node_idx[0];

endmodule : ipic_prio_search

`default_nettype wire

//--- verilog/ipic_service.sv
// In-service tracking and interrupt request
`timescale 1ns/1ns
`default_nettype none

module ipic_service #(
    parameter int N_LINES = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [N_LINES-1:0]         req_vec_i,      // Pending and enabled
    output logic                       start_o,        // SOI accepted
    output logic [$clog2(N_LINES)-1:0] start_idx_o,
    output logic                       irq_m_req_o,    // Machine interrupt request
    ipic_reg_if.service                regs
);

    localparam int               IDX_W    = $clog2(N_LINES);
    localparam int               VEC_W    = IDX_W + 1;
    localparam logic [VEC_W-1:0] VOID_VEC = VEC_W'(N_LINES);

    logic [N_LINES-1:0] isvr_q;
    logic [N_LINES-1:0] isvr_eoi;              // In service minus current line
    logic [VEC_W-1:0]   cisv_q;
    logic               serv_vd;
    logic [IDX_W-1:0]   serv_idx;
    logic               req_vd;
    logic [IDX_W-1:0]   req_idx;
    logic               eoi_vd;
    logic [IDX_W-1:0]   eoi_idx;
    logic               eoi;

    //----------------------------------------
    // Priority search
    //----------------------------------------
    ipic_prio_search #(.N_LINES(N_LINES)) u_req_search (
        .vec_i (req_vec_i),
        .vd_o  (req_vd),
        .idx_o (req_idx)
    );

    always_comb begin
        isvr_eoi = isvr_q;
        if (serv_vd) begin
            isvr_eoi[serv_idx] = 1'b0;
        end
    end

    // Next line to resume after EOI
    ipic_prio_search #(.N_LINES(N_LINES)) u_eoi_search (
        .vec_i (isvr_eoi),
        .vd_o  (eoi_vd),
        .idx_o (eoi_idx)
    );

    assign serv_vd  = ~cisv_q[VEC_W-1];        // Below N_LINES
    assign serv_idx = cisv_q[IDX_W-1:0];

    // Only a strictly higher priority request preempts
    assign irq_m_req_o = req_vd & (~serv_vd | (req_idx < serv_idx));
    assign start_o     = irq_m_req_o & regs.wr_soi;
    assign start_idx_o = req_idx;
    assign eoi         = regs.wr_eoi & serv_vd;   // EOI when idle does nothing

    //----------------------------------------
    // ISVR and CISV
    //----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isvr_q <= '0;
            cisv_q <= VOID_VEC;
        end else if (start_o) begin
            isvr_q[req_idx] <= 1'b1;
            cisv_q          <= {1'b0, req_idx};
        end else if (eoi) begin
            isvr_q <= isvr_eoi;
            cisv_q <= eoi_vd ? {1'b0, eoi_idx} : VOID_VEC;
        end
    end

    assign regs.isvr    = isvr_q;
    assign regs.cisv    = cisv_q;
    assign regs.serv_vd = serv_vd;

endmodule : ipic_service

`default_nettype wire

//--- verilog/ipic_top.sv
// Interrupt controller top level
`timescale 1ns/1ns
`default_nettype none

module ipic_top #(
    parameter int N_LINES = 16,                // Power of two, at most 32
    parameter bit SYNC_EN = 1'b1               // Lines are asynchronous
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [N_LINES-1:0]     irq_lines_i,
    input  logic                   r_req_i,
    input  logic                   w_req_i,
    input  ipic_pkg::ipic_addr_e   addr_i,
    input  ipic_pkg::ipic_word_t   wdata_i,
    output ipic_pkg::ipic_word_t   rdata_o,
    output logic                   irq_m_req_o
);

    logic [N_LINES-1:0]         lines;
    logic [N_LINES-1:0]         changed;
    logic [N_LINES-1:0]         req_vec;
    logic                       start;
    logic [$clog2(N_LINES)-1:0] start_idx;

    ipic_reg_if #(.N_LINES(N_LINES)) u_regs_if ();

    //----------------------------------------
    // Input side
    //----------------------------------------
    ipic_line_cond #(.N_LINES(N_LINES), .SYNC_EN(SYNC_EN)) u_line_cond (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .lines_o     (lines),
        .changed_o   (changed)
    );

    ipic_csr_port #(.N_LINES(N_LINES)) u_csr_port (
        .r_req_i (r_req_i),
        .w_req_i (w_req_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .regs    (u_regs_if.csr)
    );

    //----------------------------------------
    // Processing
    //----------------------------------------
    ipic_line_regs #(.N_LINES(N_LINES)) u_line_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .lines_i     (lines),
        .changed_i   (changed),
        .start_i     (start),
        .start_idx_i (start_idx),
        .req_vec_o   (req_vec),
        .regs        (u_regs_if.line)
    );

    ipic_service #(.N_LINES(N_LINES)) u_service (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_vec_i   (req_vec),
        .start_o     (start),
        .start_idx_o (start_idx),
        .irq_m_req_o (irq_m_req_o),
        .regs        (u_regs_if.service)
    );

endmodule : ipic_top

`default_nettype wire

//--- verification/ipic_chk.sv
// Interrupt controller port assertions
`timescale 1ns/1ns
`default_nettype none

module ipic_chk (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 r_req_i,
    input  wire logic                 w_req_i,
    input  wire ipic_pkg::ipic_word_t rdata_o,
    input  wire logic                 irq_m_req_o
);

    int assert_fails = 0;                      // Failed assertions so far

    // No request out of reset
    a_irq_in_reset: assert property (@(posedge clk) !rst_n |-> !irq_m_req_o)
        else begin
            $error("irq_m_req_o set while reset is asserted");
            assert_fails++;
        end

    a_rdata_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !r_req_i |-> (rdata_o == '0))
        else begin
            $error("rdata_o not zero without a read request");
            assert_fails++;
        end

    // Port never carries both
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(r_req_i && w_req_i))
        else begin
            $error("read and write requested in the same cycle");
            assert_fails++;
        end

endmodule : ipic_chk

bind ipic_top ipic_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .r_req_i     (r_req_i),
    .w_req_i     (w_req_i),
    .rdata_o     (rdata_o),
    .irq_m_req_o (irq_m_req_o)
);

`default_nettype wire

//--- verification/ipic_tb.sv
// Interrupt controller testbench
`timescale 1ns/1ns
`default_nettype none

module ipic_tb;
    import ipic_pkg::*;

    localparam int N_LINES    = 16;
    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 5;
    localparam int RAND_N     = 40;            // Random line patterns
    localparam int RAND_SEED  = 39;
    localparam int LINE_WAIT  = 6;             // Cycles after a line change

    // ICSR field values
    localparam ipic_word_t BIT_IE  = 1 << ICSR_IE;
    localparam ipic_word_t BIT_IM  = 1 << ICSR_IM;
    localparam ipic_word_t BIT_INV = 1 << ICSR_INV;
    localparam ipic_word_t PRV_FLD = ipic_word_t'(IPIC_PRV_M) << ICSR_PRV_LSB;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_LN, OP_WT} op_e;

    typedef struct {
        op_e        op;
        ipic_addr_e addr;
        ipic_word_t data;                      // Write data, line pattern or cycles
        ipic_word_t exp_rdata;
        logic       exp_irq;
        int         grp;
    } step_t;

    logic               clk;
    logic               rst_n;
    logic [N_LINES-1:0] irq_lines_i;
    logic               r_req_i;
    logic               w_req_i;
    ipic_addr_e         addr_i;
    ipic_word_t         wdata_i;
    ipic_word_t         rdata_o;
    logic               irq_m_req_o;

    step_t steps[$];
    int    cur_grp     = 0;
    int    checks      = 0;
    int    errors      = 0;
    int    grp_errs    = 0;
    int    cycles      = 0;
    int    cycle_limit = 0;
    string grp_name [6] = '{"reset values", "icsr window", "level mode",
                            "edge mode", "priority and nesting", "random lines"};

    ipic_top #(.N_LINES(N_LINES), .SYNC_EN(1'b1)) u_ipic_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .r_req_i     (r_req_i),
        .w_req_i     (w_req_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o),
        .irq_m_req_o (irq_m_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, run did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    //----------------------------------------
    // Table building
    //----------------------------------------
    task automatic push_write(input ipic_addr_e a, input ipic_word_t d);
        steps.push_back('{OP_WR, a, d, '0, 1'b0, cur_grp});
    endtask

    task automatic push_read(input ipic_addr_e a, input ipic_word_t exp, input logic irq);
        steps.push_back('{OP_RD, a, '0, exp, irq, cur_grp});
    endtask

    task automatic push_lines(input logic [N_LINES-1:0] pat);
        steps.push_back('{OP_LN, CISV, ipic_word_t'(pat), '0, 1'b0, cur_grp});
    endtask

    task automatic push_wait(input int n);
        steps.push_back('{OP_WT, CISV, ipic_word_t'(n), '0, 1'b0, cur_grp});
    endtask

    task automatic build_directed();
        int prio_lines [3] = '{9, 3, 1};
        cur_grp = 0;
        push_read(CISV, N_LINES, 1'b0);        // Void vector
        push_read(IPR, 0, 1'b0);
        push_read(ISVR, 0, 1'b0);
        push_read(IDX, 0, 1'b0);
        cur_grp = 1;
        push_write(IDX, 6);
        push_write(ICSR, BIT_IM);              // Edge mode first, no pending
        push_write(ICSR, BIT_IE | BIT_IM | BIT_INV);
        push_read(ICSR, (6 << ICSR_LN_LSB) | PRV_FLD | BIT_IE | BIT_IM | BIT_INV, 1'b0);
        push_write(IDX, 7);
        push_read(ICSR, (7 << ICSR_LN_LSB) | PRV_FLD, 1'b0);
        cur_grp = 2;
        push_write(IDX, 5);
        push_write(ICSR, BIT_IE);
        push_lines(1 << 5);
        push_wait(LINE_WAIT);
        push_read(IPR, 1 << 5, 1'b1);
        push_lines(0);
        push_wait(LINE_WAIT);
        push_read(IPR, 0, 1'b0);
        push_write(ICSR, BIT_IE | BIT_INV);    // Low line now active
        push_read(IPR, 1 << 5, 1'b1);
        push_lines(1 << 5);
        push_wait(LINE_WAIT);
        push_read(IPR, 0, 1'b0);
        push_write(ICSR, 0);                   // Disable and restore polarity
        push_lines(0);
        push_wait(LINE_WAIT);
        push_read(IPR, 0, 1'b0);
        cur_grp = 3;
        push_write(IDX, 2);
        push_write(ICSR, BIT_IE | BIT_IM);
        push_lines(1 << 2);                    // One cycle pulse
        push_lines(0);
        push_wait(LINE_WAIT);
        push_read(IPR, 1 << 2, 1'b1);          // Held after the line drops
        push_write(IPR, 1 << 2);
        push_read(IPR, 0, 1'b0);
        cur_grp = 4;
        foreach (prio_lines[k]) begin
            push_write(IDX, prio_lines[k]);
            push_write(ICSR, BIT_IE);
        end
        push_lines((1 << 9) | (1 << 3));
        push_wait(LINE_WAIT);
        push_read(IPR, (1 << 9) | (1 << 3), 1'b1);
        push_write(SOI, 0);                    // Line 3 wins
        push_read(CISV, 3, 1'b0);
        push_read(ISVR, 1 << 3, 1'b0);
        push_lines((1 << 9) | (1 << 3) | (1 << 1));
        push_wait(LINE_WAIT);
        push_read(IPR, (1 << 9) | (1 << 3) | (1 << 1), 1'b1);   // Preempts line 3
        push_write(EOI, 0);
        push_read(CISV, N_LINES, 1'b1);
        push_read(ISVR, 0, 1'b1);
        push_write(SOI, 0);
        push_read(CISV, 1, 1'b0);
        push_read(ISVR, 1 << 1, 1'b0);
        push_write(EOI, 0);                    // Leave nothing in service
        push_lines(0);
        push_wait(LINE_WAIT);
        push_read(IPR, 0, 1'b0);
    endtask

    task automatic build_random();
        logic [N_LINES-1:0] pat;
        cur_grp = 5;
        for (int i = 0; i < N_LINES; i++) begin
            push_write(IDX, i);
            push_write(ICSR, BIT_IE);          // Level mode, not inverted
        end
        for (int i = 0; i < RAND_N; i++) begin
            pat = N_LINES'($urandom());
            push_lines(pat);
            push_wait(LINE_WAIT);
            push_read(IPR, ipic_word_t'(pat), pat != '0);
        end
    endtask

    //----------------------------------------
    // Checks
    //----------------------------------------
    task automatic check_rdata(input ipic_word_t got, input ipic_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            grp_errs++;
            $display("Fail at %0t ns: rdata_o = %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            grp_errs++;
            $display("Fail at %0t ns: irq_m_req_o = %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic apply_step(input step_t s);
        @(negedge clk);
        r_req_i = 1'b0;
        w_req_i = 1'b0;
        case (s.op)
            OP_WR: begin
                w_req_i = 1'b1;
                addr_i  = s.addr;
                wdata_i = s.data;
            end
            OP_RD: begin
                r_req_i = 1'b1;
                addr_i  = s.addr;
                #(CLK_PERIOD/4);               // Mid low phase, outputs settled
                check_rdata(rdata_o, s.exp_rdata);
                check_irq(irq_m_req_o, s.exp_irq);
            end
            OP_LN: irq_lines_i = s.data[N_LINES-1:0];
            OP_WT: repeat (s.data) @(negedge clk);
        endcase
    endtask

    initial begin
        int fixed_len;
        int fails;
        rst_n       = 1'b0;
        irq_lines_i = '0;
        r_req_i     = 1'b0;
        w_req_i     = 1'b0;
        addr_i      = CISV;
        wdata_i     = '0;
        void'($urandom(RAND_SEED));
        build_directed();
        fixed_len   = steps.size();
        cycle_limit = fixed_len * 8 + RAND_N * 8 + 100;
        build_random();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(steps[i]);
            if (i == steps.size() - 1 || steps[i+1].grp != steps[i].grp) begin
                $display("Group %0d %s: %0d errors", steps[i].grp,
                         grp_name[steps[i].grp], grp_errs);
                grp_errs = 0;
            end
        end
        @(negedge clk);
        r_req_i = 1'b0;
        w_req_i = 1'b0;
        fails   = u_ipic_top.u_chk.assert_fails;
        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : ipic_tb

`default_nettype wire

//--- build.f
verilog/ipic_pkg.sv
verilog/ipic_reg_if.sv
verilog/ipic_line_cond.sv
verilog/ipic_csr_port.sv
verilog/ipic_line_regs.sv
verilog/ipic_prio_search.sv
verilog/ipic_service.sv
verilog/ipic_top.sv
verification/ipic_chk.sv
verification/ipic_tb.sv
